// File: src/key_pkg.sv
package key_pkg;

  localparam int SCAN_W = 9;  // bit 8 flags an extended code
  localparam int NUM_DIGITS = 10;

  // main row, index is the digit
  localparam logic [0:NUM_DIGITS-1][SCAN_W-1:0] DIGIT_CODES = {
    9'h045,
    9'h016,
    9'h01e,
    9'h026,
    9'h025,
    9'h02e,
    9'h036,
    9'h03d,
    9'h03e,
    9'h046
  };

  // numeric keypad, same order
  localparam logic [0:NUM_DIGITS-1][SCAN_W-1:0] PAD_CODES = {
    9'h070,
    9'h069,
    9'h072,
    9'h07a,
    9'h06b,
    9'h073,
    9'h074,
    9'h06c,
    9'h075,
    9'h07d
  };

  localparam logic [SCAN_W-1:0] SPACE_CODE = 9'h029;

endpackage

// File: src/game_pkg.sv
package game_pkg;

  localparam int NUM_SLOTS = 10;  // one lamp per digit key

  // game second, kept short for simulation
  localparam int TICKS_PER_SECOND = 40;
  localparam int TICK_W = $clog2(TICKS_PER_SECOND);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SECOND - 1);

  localparam int FINAL_SECONDS = 4;
  localparam int FINAL_W = $clog2(FINAL_SECONDS + 1);
  localparam logic [FINAL_W-1:0] FINAL_LAST = FINAL_W'(FINAL_SECONDS - 1);

  localparam logic [7:0] DEFAULT_TIME = 8'h30;  // bcd
  localparam logic [7:0] DEFAULT_GOAL = 8'h10;

  localparam int LFSR_W = 9;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 9'b1_0110_0000;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 9'b0_0110_1000;  // xor into bits 6, 5, 3

  typedef enum logic [1:0] {
    INIT,
    SET,
    GAME,
    FINAL
  } game_state_e;

  // symbol codes, digits 0 and 5 double as O and S
  localparam logic [3:0] GLYPH_BLANK = 4'hf;
  localparam logic [3:0] GLYPH_W = 4'ha;
  localparam logic [3:0] GLYPH_I = 4'hb;
  localparam logic [3:0] GLYPH_N = 4'hc;
  localparam logic [3:0] GLYPH_L = 4'hd;
  localparam logic [3:0] GLYPH_O = 4'h0;
  localparam logic [3:0] GLYPH_S = 4'h5;
  localparam logic [3:0] GLYPH_E = 4'he;

  // bcd[1] is the time byte, bcd[0] the goal or score byte
  // glyph[3] is the leftmost symbol
  typedef union packed {
    logic [1:0][7:0] bcd;
    logic [3:0][3:0] glyph;
  } display_word_u;

endpackage

// File: src/key_decoder.sv
`timescale 1ns/1ns

module key_decoder (
  input  logic                      clk,
  input  logic                      out_rst,
  input  logic                      scan_valid,
  input  logic [key_pkg::SCAN_W-1:0] scan_code,
  input  logic                      scan_release,
  output logic                      digit_press,
  output logic [3:0]                digit_value,
  output logic                      space_press
);

  logic                       is_digit;
  logic [3:0]                 dig_val;
  logic                       is_space;
  logic                       held;
  logic [key_pkg::SCAN_W-1:0] last_code;
  logic                       fresh;

  always_comb begin
    is_digit = 1'b0;
    dig_val  = 4'd0;
    for (int i = 0; i < key_pkg::NUM_DIGITS; i++) begin
      if (scan_code == key_pkg::DIGIT_CODES[i] || scan_code == key_pkg::PAD_CODES[i]) begin
        is_digit = 1'b1;
        dig_val  = 4'(i);
      end
    end
  end

  assign is_space = (scan_code == key_pkg::SPACE_CODE);
  // make code that is not typematic repeat of the held key
  assign fresh = scan_valid && !scan_release && !(held && scan_code == last_code);

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      held        <= 1'b0;
      digit_press <= 1'b0;
      space_press <= 1'b0;
    end else begin
      digit_press <= fresh && is_digit;
      space_press <= fresh && is_space;
      if (fresh)
        held <= 1'b1;
      else if (scan_valid && scan_release && scan_code == last_code)
        held <= 1'b0;  // released
    end
  end

  always_ff @(posedge clk) begin
    if (fresh)
      last_code <= scan_code;
    if (fresh && is_digit)
      digit_value <= dig_val;
  end

  a_one_press: assert property (@(posedge clk) disable iff (out_rst)
    !(digit_press && space_press));

endmodule

// File: src/target_spawner.sv
`timescale 1ns/1ns

module target_spawner (
  input  logic                           clk,
  input  logic                           out_rst,
  input  logic                           round_active,
  input  logic                           second_tick,
  output logic                           load_pulse,
  output logic [game_pkg::NUM_SLOTS-1:0] pattern
);

  logic [game_pkg::LFSR_W-1:0] lfsr;
  logic                        round_q;
  logic                        step;

  assign step = round_active && second_tick;

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lfsr       <= game_pkg::LFSR_SEED;
      round_q    <= 1'b0;
      load_pulse <= 1'b0;
    end else begin
      round_q    <= round_active;
      // first cycle of a round, then every second
      load_pulse <= step || (round_active && !round_q);
      if (!round_active)
        lfsr <= game_pkg::LFSR_SEED;
      else if (step)
        lfsr <= {lfsr[0], lfsr[game_pkg::LFSR_W-1:1]}
                ^ (lfsr[0] ? game_pkg::LFSR_TAPS : '0);
    end
  end

  // lamp 0 always lit so a pattern is never empty
  assign pattern = {lfsr, 1'b1};

endmodule

// File: src/target_slot.sv
`timescale 1ns/1ns

module target_slot #(
  parameter int IDX = 0
) (
  input  logic       clk,
  input  logic       out_rst,
  input  logic       load_pulse,
  input  logic       pattern_bit,
  input  logic       round_active,
  input  logic       digit_press,
  input  logic [3:0] digit_value,
  output logic       lit,
  output logic       hit
);

  logic match;

  assign match = digit_press && (digit_value == 4'(IDX));

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lit <= 1'b0;
      hit <= 1'b0;
    end else begin
      hit <= 1'b0;
      if (!round_active) begin
        lit <= 1'b0;
      end else if (match && lit) begin
        hit <= 1'b1;  // whacked, lamp goes dark
        lit <= 1'b0;
      end else if (load_pulse) begin
        lit <= pattern_bit;
      end
    end
  end

  a_hit_lit: assert property (@(posedge clk) disable iff (out_rst)
    hit |-> $past(lit));

endmodule

// File: src/score_tally.sv
`timescale 1ns/1ns

module score_tally (
  input  logic                           clk,
  input  logic                           out_rst,
  input  logic                           score_clear,
  input  logic [game_pkg::NUM_SLOTS-1:0] hit,
  output logic [7:0]                     score
);

  logic [3:0] hit_cnt;
  logic [4:0] ones_sum;
  logic       carry;
  logic [4:0] ones_adj;
  logic [3:0] tens_sum;
  logic [7:0] next_score;

  always_comb begin
    hit_cnt = 4'd0;
    for (int i = 0; i < game_pkg::NUM_SLOTS; i++)
      hit_cnt = hit_cnt + 4'(hit[i]);
    ones_sum = {1'b0, score[3:0]} + {1'b0, hit_cnt};  // at most 19
    carry    = (ones_sum >= 5'd10);
    ones_adj = carry ? ones_sum - 5'd10 : ones_sum;
    tens_sum = score[7:4] + {3'b000, carry};
    if (tens_sum > 4'd9)
      next_score = 8'h99;  // saturate
    else
      next_score = {tens_sum, ones_adj[3:0]};
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst)
      score <= 8'h00;
    else if (score_clear)
      score <= 8'h00;
    else
      score <= next_score;
  end

endmodule

// File: src/game_ctrl.sv
`timescale 1ns/1ns

module game_ctrl (
  input  logic                    clk,
  input  logic                    out_rst,
  input  logic                    start,
  input  logic                    digit_press,
  input  logic [3:0]              digit_value,
  input  logic                    space_press,
  input  logic [7:0]              score,
  output logic                    round_active,
  output logic                    second_tick,
  output logic                    score_clear,
  output game_pkg::display_word_u display_word,
  output logic                    show_glyph,
  output logic                    set_goal_mode
);

  game_pkg::game_state_e       state;
  game_pkg::game_state_e       next_state;
  logic [7:0]                  time_bcd;
  logic [7:0]                  goal_bcd;
  logic                        won;
  logic [game_pkg::TICK_W-1:0] tick_cnt;
  logic [game_pkg::FINAL_W-1:0] final_secs;
  logic [7:0]                  score_live;
  logic                        win_now;
  logic                        lose_now;
  logic                        final_done;
  game_pkg::display_word_u     word_d;
  logic                        glyph_d;

  assign round_active = (state == game_pkg::GAME);
  assign second_tick  = (round_active || state == game_pkg::FINAL)
                        && tick_cnt == game_pkg::TICK_LAST;

  // tally still holds last round's score while the clear is in flight
  assign score_live = (round_active && !score_clear) ? score : 8'h00;
  assign win_now    = round_active && !score_clear && score == goal_bcd;
  assign lose_now   = round_active && time_bcd == 8'h00;
  assign final_done = state == game_pkg::FINAL && second_tick
                      && final_secs == game_pkg::FINAL_LAST;

  always_comb begin
    next_state = state;
    case (state)
      game_pkg::INIT:  if (start) next_state = game_pkg::SET;
      game_pkg::SET:   if (start) next_state = game_pkg::GAME;
      game_pkg::GAME:  if (win_now || lose_now) next_state = game_pkg::FINAL;
      game_pkg::FINAL: if (final_done) next_state = game_pkg::INIT;
      default:         next_state = game_pkg::INIT;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      state         <= game_pkg::INIT;
      time_bcd      <= game_pkg::DEFAULT_TIME;
      goal_bcd      <= game_pkg::DEFAULT_GOAL;
      set_goal_mode <= 1'b0;
      won           <= 1'b0;
      score_clear   <= 1'b0;
    end else begin
      state       <= next_state;
      score_clear <= (state == game_pkg::SET) && (next_state == game_pkg::GAME);
      case (state)
        game_pkg::INIT: begin
          time_bcd      <= game_pkg::DEFAULT_TIME;
          goal_bcd      <= game_pkg::DEFAULT_GOAL;
          set_goal_mode <= 1'b0;
        end
        game_pkg::SET: begin
          if (digit_press) begin
            if (set_goal_mode)
              goal_bcd <= {goal_bcd[3:0], digit_value};  // shift in from the right
            else
              time_bcd <= {time_bcd[3:0], digit_value};
          end
          if (space_press)
            set_goal_mode <= !set_goal_mode;
        end
        game_pkg::GAME: begin
          if (second_tick && time_bcd != 8'h00) begin
            if (time_bcd[3:0] == 4'd0)
              time_bcd <= {time_bcd[7:4] - 4'd1, 4'd9};  // bcd borrow
            else
              time_bcd <= time_bcd - 8'd1;
          end
          if (next_state == game_pkg::FINAL)
            won <= win_now;
        end
        default: ;
      endcase
    end
  end

  // second counter, restarted on every state change
  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      tick_cnt   <= '0;
      final_secs <= '0;
    end else begin
      if (next_state != state || !(round_active || state == game_pkg::FINAL))
        tick_cnt <= '0;
      else if (second_tick)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;
      if (state != game_pkg::FINAL)
        final_secs <= '0;
      else if (second_tick)
        final_secs <= final_secs + 1'b1;
    end
  end

  // built from next_state so the glyphs rise with the move to FINAL
  always_comb begin
    word_d.glyph = {4{game_pkg::GLYPH_BLANK}};
    glyph_d      = 1'b1;
    case (next_state)
      game_pkg::SET: begin
        word_d.bcd = {time_bcd, goal_bcd};
        glyph_d    = 1'b0;
      end
      game_pkg::GAME: begin
        word_d.bcd = {time_bcd, score_live};
        glyph_d    = 1'b0;
      end
      game_pkg::FINAL: begin
        if ((state == game_pkg::FINAL) ? won : win_now)
          word_d.glyph = {game_pkg::GLYPH_W, game_pkg::GLYPH_I,
                          game_pkg::GLYPH_N, game_pkg::GLYPH_BLANK};
        else
          word_d.glyph = {game_pkg::GLYPH_L, game_pkg::GLYPH_O,
                          game_pkg::GLYPH_S, game_pkg::GLYPH_E};
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      display_word.glyph <= {4{game_pkg::GLYPH_BLANK}};
      show_glyph         <= 1'b1;
    end else begin
      display_word <= word_d;
      show_glyph   <= glyph_d;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (out_rst)
    state inside {game_pkg::INIT, game_pkg::SET, game_pkg::GAME, game_pkg::FINAL});

endmodule

// File: src/whack_top.sv
`timescale 1ns/1ns

module whack_top (
  input  logic                           clk,
  input  logic                           out_rst,
  input  logic                           start,
  input  logic                           scan_valid,
  input  logic [key_pkg::SCAN_W-1:0]     scan_code,
  input  logic                           scan_release,
  output logic [game_pkg::NUM_SLOTS-1:0] leds,
  output game_pkg::display_word_u        display_word,
  output logic                           show_glyph,
  output logic                           set_goal_mode
);

  logic                           digit_press;
  logic [3:0]                     digit_value;
  logic                           space_press;
  logic                           round_active;
  logic                           second_tick;
  logic                           load_pulse;
  logic [game_pkg::NUM_SLOTS-1:0] pattern;
  logic [game_pkg::NUM_SLOTS-1:0] hit;
  logic [7:0]                     score;
  logic                           score_clear;

  key_decoder u_keys (
    .clk          (clk),
    .out_rst      (out_rst),
    .scan_valid   (scan_valid),
    .scan_code    (scan_code),
    .scan_release (scan_release),
    .digit_press  (digit_press),
    .digit_value  (digit_value),
    .space_press  (space_press)
  );

  target_spawner u_spawner (
    .clk          (clk),
    .out_rst      (out_rst),
    .round_active (round_active),
    .second_tick  (second_tick),
    .load_pulse   (load_pulse),
    .pattern      (pattern)
  );

  for (genvar i = 0; i < game_pkg::NUM_SLOTS; i++) begin : g_slot
    target_slot #(.IDX(i)) u_slot (
      .clk          (clk),
      .out_rst      (out_rst),
      .load_pulse   (load_pulse),
      .pattern_bit  (pattern[i]),
      .round_active (round_active),
      .digit_press  (digit_press),
      .digit_value  (digit_value),
      .lit          (leds[i]),
      .hit          (hit[i])
    );
  end

  score_tally u_tally (
    .clk         (clk),
    .out_rst     (out_rst),
    .score_clear (score_clear),
    .hit         (hit),
    .score       (score)
  );

  game_ctrl u_ctrl (
    .clk           (clk),
    .out_rst       (out_rst),
    .start         (start),
    .digit_press   (digit_press),
    .digit_value   (digit_value),
    .space_press   (space_press),
    .score         (score),
    .round_active  (round_active),
    .second_tick   (second_tick),
    .score_clear   (score_clear),
    .display_word  (display_word),
    .show_glyph    (show_glyph),
    .set_goal_mode (set_goal_mode)
  );

endmodule

// File: testbench/tb_whack.sv
`timescale 1ns/1ns

module tb_whack;

  logic                           clk;
  logic                           out_rst;
  logic                           start;
  logic                           scan_valid;
  logic [key_pkg::SCAN_W-1:0]     scan_code;
  logic                           scan_release;
  logic [game_pkg::NUM_SLOTS-1:0] leds;
  game_pkg::display_word_u        display_word;
  logic                           show_glyph;
  logic                           set_goal_mode;

  logic [15:0] golden [0:255];  // three words per record
  int          mismatch_cnt;
  int          fault_cnt;
  int          check_cnt;
  bit          aborted;

  whack_top dut (
    .clk           (clk),
    .out_rst       (out_rst),
    .start         (start),
    .scan_valid    (scan_valid),
    .scan_code     (scan_code),
    .scan_release  (scan_release),
    .leds          (leds),
    .display_word  (display_word),
    .show_glyph    (show_glyph),
    .set_goal_mode (set_goal_mode)
  );

  always #10 clk = ~clk;

  // every step lands 2 ns after a rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_word(input game_pkg::display_word_u got,
                            input game_pkg::display_word_u exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Mismatch display_word: got %h expected %h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_leds(input logic [game_pkg::NUM_SLOTS-1:0] got,
                            input logic [game_pkg::NUM_SLOTS-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Mismatch leds: got %h expected %h", got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic send_scan(input logic [key_pkg::SCAN_W-1:0] code, input logic brk);
    scan_valid   = 1'b1;
    scan_code    = code;
    scan_release = brk;
    next_cycle();
    scan_valid   = 1'b0;
    scan_release = 1'b0;
  endtask

  task automatic tap_key(input logic [key_pkg::SCAN_W-1:0] code);
    send_scan(code, 1'b0);
    send_scan(code, 1'b1);
    repeat (3) next_cycle();  // press, register, display
  endtask

  task automatic pulse_start();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    repeat (2) next_cycle();
  endtask

  function automatic int lowest_lit(input logic [game_pkg::NUM_SLOTS-1:0] v);
    int idx;
    idx = -1;
    for (int i = game_pkg::NUM_SLOTS - 1; i >= 0; i--)
      if (v[i])
        idx = i;
    return idx;
  endfunction

  task automatic whack_lowest();
    int n;
    int idx;
    n = 0;
    while (leds == '0 && n < 2 * game_pkg::TICKS_PER_SECOND) begin
      next_cycle();
      n++;
    end
    idx = lowest_lit(leds);
    if (idx < 0) begin
      $display("timeout: no target lamp lit to whack");
      fault_cnt++;
      aborted = 1'b1;
    end else begin
      send_scan(key_pkg::DIGIT_CODES[idx], 1'b0);
      send_scan(key_pkg::DIGIT_CODES[idx], 1'b1);
      check_flag($sformatf("leds[%0d]", idx), leds[idx], 1'b0);  // just past the hit edge
      repeat (2) next_cycle();  // score, then display word
    end
  endtask

  task automatic wait_glyph_on();
    int n;
    n = 0;
    while (show_glyph !== 1'b1 && n < 10 * game_pkg::TICKS_PER_SECOND) begin
      next_cycle();
      n++;
    end
    if (show_glyph !== 1'b1) begin
      $display("timeout: round never ended with result glyphs");
      fault_cnt++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_init_entry();
    int n;
    n = 0;
    while (display_word !== {4{game_pkg::GLYPH_BLANK}}
           && n < (game_pkg::FINAL_SECONDS + 2) * game_pkg::TICKS_PER_SECOND) begin
      next_cycle();
      n++;
    end
    if (display_word !== {4{game_pkg::GLYPH_BLANK}}) begin
      $display("timeout: game never returned to the idle state");
      fault_cnt++;
      aborted = 1'b1;
    end else begin
      next_cycle();  // settings reload one cycle after entering INIT
    end
  endtask

  task automatic check_expect(input logic [15:0] sel, input logic [15:0] exp);
    game_pkg::display_word_u exp_word;
    exp_word = exp;
    case (sel)
      16'h0: check_word(display_word, exp_word);
      16'h1: check_leds(leds, exp[game_pkg::NUM_SLOTS-1:0]);
      16'h2: check_flag("show_glyph", show_glyph, exp[0]);
      16'h3: check_flag("set_goal_mode", set_goal_mode, exp[0]);
      default: begin
        $display("golden file asks to check unknown output %h", sel);
        fault_cnt++;
      end
    endcase
  endtask

  initial begin
    int          rec;
    logic [15:0] op;
    logic [15:0] arg;
    logic [15:0] exp;
    bit          done;
    clk          = 1'b0;
    out_rst      = 1'b1;
    start        = 1'b0;
    scan_valid   = 1'b0;
    scan_code    = '0;
    scan_release = 1'b0;
    mismatch_cnt = 0;
    fault_cnt    = 0;
    check_cnt    = 0;
    aborted      = 1'b0;
    done         = 1'b0;
    $readmemh("testbench/whack_golden.txt", golden);
    repeat (8) @(posedge clk);
    #2;
    out_rst = 1'b0;

    rec = 0;
    while (!done && !aborted && 3 * rec + 2 < 256) begin
      op  = golden[3 * rec];
      arg = golden[3 * rec + 1];
      exp = golden[3 * rec + 2];
      case (op)
        16'h0: done = 1'b1;
        16'h1: tap_key(arg[key_pkg::SCAN_W-1:0]);
        16'h2: begin
          send_scan(arg[key_pkg::SCAN_W-1:0], 1'b0);  // make only
          repeat (3) next_cycle();
        end
        16'h3: begin
          send_scan(arg[key_pkg::SCAN_W-1:0], 1'b1);
          repeat (3) next_cycle();
        end
        16'h4: pulse_start();
        16'h5: whack_lowest();
        16'h6: wait_glyph_on();
        16'h7: wait_init_entry();
        16'h8: check_expect(arg, exp);
        default: begin
          $display("golden record %0d has unknown opcode %h", rec, op);
          fault_cnt++;
          aborted = 1'b1;
        end
      endcase
      rec++;
    end
    if (!done && !aborted) begin
      $display("golden file has no end record");
      fault_cnt++;
    end
    if (check_cnt == 0) begin
      $display("no checks were run");
      fault_cnt++;
    end

    $display("%0d checks, %0d mismatches, %0d other failures",
             check_cnt, mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: testbench/whack_golden.txt
// records of three hex words: opcode, scan code or output select, expected value
// op 1 key 2 make 3 break 4 start 5 whack 6 wait_glyph 7 wait_init 8 expect 0 end
// expect select 0 display_word 1 leds 2 show_glyph 3 set_goal_mode
8 0 ffff  8 1 0000  8 2 0001  8 3 0000          // after reset
4 0 0000  8 0 3010  8 2 0000                    // defaults in SET
1 025 0000  8 0 0410  1 073 0000  8 0 4510      // main row 4, keypad 5
3 016 0000  8 0 4510  1 01c 0000  8 0 4510      // lone break, unknown code
2 016 0000  8 0 5110  2 016 0000  8 0 5110      // typematic repeat ignored
3 016 0000
1 06b 0000  8 0 1410  1 02e 0000  8 0 4510
1 029 0000  8 3 0001  1 045 0000  1 026 0000    // goal field
8 0 4503  1 029 0000  8 3 0000
4 0 0000  8 0 4500  5 0 0000  8 0 4501          // round one
1 016 0000  8 0 4501                            // lamp 1 is dark
5 0 0000  8 0 4502  5 0 0000
6 0 0000  8 2 0001  8 0 abcf                    // win
7 0 0000  8 0 ffff  8 1 0000
4 0 0000  8 0 3010  1 045 0000  1 01e 0000      // round two, time 02
8 0 0210  1 029 0000  1 046 0000  1 046 0000
8 0 0299  8 3 0001
4 0 0000  6 0 0000  8 0 d05e  8 2 0001          // lose
7 0 0000  8 0 ffff  8 1 0000  8 3 0000
0 0 0000

// File: tb.f
src/key_pkg.sv
src/game_pkg.sv
src/key_decoder.sv
src/target_spawner.sv
src/target_slot.sv
src/score_tally.sv
src/game_ctrl.sv
src/whack_top.sv
testbench/tb_whack.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_whack
RTL_TOP   ?= whack_top
FILELIST  ?= tb.f
VFLAGS    ?= --assert --timing
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
